//--- video_cfg.svh
/*
 * Video output stage configuration
 * Raster geometry, CPU register map and pixel pipeline latency
 */
`ifndef VIDEO_CFG_SVH
`define VIDEO_CFG_SVH

// Horizontal geometry in pixels
`define H_TOTAL         512
`define H_ACTIVE        384
`define H_SYNC_START    416
`define H_SYNC_END      448

// Vertical geometry in lines
`define V_TOTAL         262
`define V_ACTIVE        224
`define V_SYNC_START    234
`define V_SYNC_END      237

// CPU register addresses
`define REG_LAYER_ORDER 0
`define REG_LAYER_EN    1
`define REG_PAL_ADDR    2
`define REG_PAL_DATA    3

// Pen value that lets the layer behind show through
`define PEN_TRANSPARENT 15

// Clocks from a layers sample to the matching video output
`define PIPE_DEPTH      2

`endif

//--- video_pkg.sv
/*
 * Video output stage types
 * Layer pixels, mixer control, palette access, raster and video buses
 */
package video_pkg;

    typedef enum logic [1:0] {
        LAYER_SCR1 = 2'd0,
        LAYER_SCR2 = 2'd1,
        LAYER_SCR3 = 2'd2,
        LAYER_OBJ  = 2'd3
    } layer_id_e;

    typedef struct packed {
        logic [4:0] pal;
        logic [3:0] pen;
    } layer_pxl_t;

    typedef struct packed {
        layer_pxl_t scr1;
        layer_pxl_t scr2;
        layer_pxl_t scr3;
        layer_pxl_t obj;
    } layer_set_t;

    // One entry of the 2048-colour palette
    typedef struct packed {
        layer_id_e  layer;
        logic [4:0] pal;
        logic [3:0] pen;
    } pal_index_t;

    // Slot 0 of order is the frontmost layer, en is indexed by layer id
    typedef struct packed {
        layer_id_e [3:0] order;
        logic      [3:0] en;
    } mix_ctrl_t;

    typedef struct packed {
        logic        we;
        pal_index_t  addr;
        logic [15:0] data;
    } pal_wr_t;

    typedef struct packed {
        logic [8:0] hdump;
        logic [8:0] vdump;
        logic       hs;
        logic       vs;
        logic       hb;
        logic       vb;
    } raster_t;

    typedef struct packed {
        logic       hs;
        logic       vs;
        logic       hb;
        logic       vb;
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } video_out_t;

    typedef struct packed {
        logic [3:0]  addr;
        logic [15:0] data;
    } cpu_wr_t;

endpackage

//--- video_timing.sv
/*
 * Raster timing generator
 * Free-running pixel and line counters with sync and blanking decode,
 * one pixel per clock
 */
`timescale 1ns/1ps
`include "video_cfg.svh"

module video_timing
    import video_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    output raster_t raster
);

    logic [8:0] hcnt;
    logic [8:0] vcnt;
    logic       line_end;
    logic       frame_end;

    assign line_end  = (hcnt == 9'(`H_TOTAL - 1));
    assign frame_end = (vcnt == 9'(`V_TOTAL - 1));

    // Line counter advances on every clock
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hcnt <= '0;
        end else if (line_end) begin
            hcnt <= '0;
        end else begin
            hcnt <= hcnt + 9'd1;
        end
    end

    // Frame counter steps once per line wrap
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vcnt <= '0;
        end else if (line_end) begin
            if (frame_end) begin
                vcnt <= '0;
            end else begin
                vcnt <= vcnt + 9'd1;
            end
        end
    end

    // Flags decoded straight from the counters
    always_comb begin
        raster.hdump = hcnt;
        raster.vdump = vcnt;
        raster.hb    = (hcnt >= 9'(`H_ACTIVE));
        raster.vb    = (vcnt >= 9'(`V_ACTIVE));
        raster.hs    = (hcnt >= 9'(`H_SYNC_START)) && (hcnt < 9'(`H_SYNC_END));
        raster.vs    = (vcnt >= 9'(`V_SYNC_START)) && (vcnt < 9'(`V_SYNC_END));
    end

endmodule

//--- ppu_reg_decode.sv
/*
 * Video register write port
 * Four-phase req/ack slave, layer order and enable registers,
 * auto-incrementing palette pointer and palette write strobe
 */
`timescale 1ns/1ps
`include "video_cfg.svh"

module ppu_reg_decode
    import video_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      cpu_req,
    input  cpu_wr_t   cpu_wr,
    output logic      cpu_ack,
    output mix_ctrl_t mix_ctrl,
    output pal_wr_t   pal_wr
);

    logic        wr_fire;
    logic        pal_we;
    pal_index_t  pal_ptr;
    pal_index_t  pal_addr_q;
    logic [15:0] pal_data_q;

    // A write lands on the edge where ack rises
    assign wr_fire = cpu_req && !cpu_ack;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_ack <= 1'b0;
            pal_we  <= 1'b0;
            pal_ptr <= '0;
            mix_ctrl.en <= 4'hf;
            // scr1 in front, obj at the back
            for (int i = 0; i < 4; i++) begin
                mix_ctrl.order[i] <= layer_id_e'(i);
            end
        end else begin
            cpu_ack <= cpu_req;
            pal_we  <= 1'b0;
            if (wr_fire) begin
                case (cpu_wr.addr)
                    `REG_LAYER_ORDER: begin
                        for (int i = 0; i < 4; i++) begin
                            mix_ctrl.order[i] <= layer_id_e'(cpu_wr.data[2*i +: 2]);
                        end
                    end
                    `REG_LAYER_EN: begin
                        mix_ctrl.en <= cpu_wr.data[3:0];
                    end
                    `REG_PAL_ADDR: begin
                        pal_ptr <= pal_index_t'(cpu_wr.data[10:0]);
                    end
                    `REG_PAL_DATA: begin
                        pal_we  <= 1'b1;
                        pal_ptr <= pal_index_t'(pal_ptr + 11'd1);
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // Address and colour for the palette write, taken before the pointer moves
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            pal_addr_q <= pal_ptr;
            pal_data_q <= cpu_wr.data;
        end
    end

    always_comb begin
        pal_wr.we   = pal_we;
        pal_wr.addr = pal_addr_q;
        pal_wr.data = pal_data_q;
    end

    // Strobe only for a data register write, and only as ack rises
    a_strobe_on_ack: assert property (@(posedge clk) disable iff (rst)
        pal_wr.we == ($rose(cpu_ack) && $past(cpu_wr.addr) == 4'(`REG_PAL_DATA)))
        else $error("palette write strobe not matched to a data register handshake");

    a_single_strobe: assert property (@(posedge clk) disable iff (rst)
        pal_wr.we |=> !pal_wr.we)
        else $error("palette write strobe held for two cycles");

endmodule

//--- layer_mix_exec.sv
/*
 * Layer priority mixer
 * Picks the frontmost enabled, non-transparent layer pixel by the
 * programmed order and registers its palette index
 */
`timescale 1ns/1ps
`include "video_cfg.svh"

module layer_mix_exec
    import video_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  layer_set_t layers,
    input  mix_ctrl_t  mix_ctrl,
    output pal_index_t mix_pxl
);

    layer_pxl_t by_id [4];
    pal_index_t pick;
    logic       found;
    logic       pick_ok;

    // Pixels reachable by layer id
    always_comb begin
        by_id[LAYER_SCR1] = layers.scr1;
        by_id[LAYER_SCR2] = layers.scr2;
        by_id[LAYER_SCR3] = layers.scr3;
        by_id[LAYER_OBJ]  = layers.obj;
    end

    // Front to back walk, first hit wins
    always_comb begin
        layer_id_e slot;
        slot  = LAYER_SCR1;
        pick  = '0;
        found = 1'b0;
        for (int i = 0; i < 4; i++) begin
            slot = mix_ctrl.order[i];
            if (!found && mix_ctrl.en[slot] &&
                by_id[slot].pen != 4'(`PEN_TRANSPARENT)) begin
                found      = 1'b1;
                pick.layer = slot;
                pick.pal   = by_id[slot].pal;
                pick.pen   = by_id[slot].pen;
            end
        end
    end

    // Backdrop is palette entry 0 when nothing qualifies
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mix_pxl <= '0;
        end else begin
            mix_pxl <= pick;
        end
    end

    // Independent check of the chosen layer's pixel
    assign pick_ok = mix_ctrl.en[pick.layer] &&
                     by_id[pick.layer].pen != 4'(`PEN_TRANSPARENT) &&
                     by_id[pick.layer].pal == pick.pal &&
                     by_id[pick.layer].pen == pick.pen;

    a_layer_field: assert property (@(posedge clk) disable iff (rst)
        1'b1 |=> (!$past(found) && mix_pxl == '0) ||
                 ($past(found) && $past(pick_ok) && mix_pxl.layer == $past(pick.layer)))
        else $error("mixer index does not name the chosen layer or the backdrop");

endmodule

//--- pal_result.sv
/*
 * Palette lookup and video output
 * 2048x16 palette RAM, 4 to 8 bit colour expansion and blanking,
 * with sync and blank flags delayed to match the pixel
 */
`timescale 1ns/1ps
`include "video_cfg.svh"

module pal_result
    import video_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  pal_index_t mix_pxl,
    input  raster_t    raster,
    input  pal_wr_t    pal_wr,
    output video_out_t video
);

    logic [15:0] pal_ram [2048];
    logic [15:0] pal_rd;
    logic [3:0]  raster_flags;
    logic [3:0]  flag_pipe [`PIPE_DEPTH];
    logic [3:0]  out_flags;
    logic        blank;

    // Flags in hs, vs, hb, vb order
    assign raster_flags = {raster.hs, raster.vs, raster.hb, raster.vb};

    // One stage per pipeline clock, mixer then palette read
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `PIPE_DEPTH; i++) begin
                flag_pipe[i] <= 4'b0011;
            end
        end else begin
            flag_pipe[0] <= raster_flags;
            for (int i = 1; i < `PIPE_DEPTH; i++) begin
                flag_pipe[i] <= flag_pipe[i-1];
            end
        end
    end

    // Read returns the old entry when both ports hit the same address
    always_ff @(posedge clk) begin
        if (pal_wr.we) begin
            pal_ram[pal_wr.addr] <= pal_wr.data;
        end
        pal_rd <= pal_ram[mix_pxl];
    end

    assign out_flags = flag_pipe[`PIPE_DEPTH-1];
    assign blank     = out_flags[1] || out_flags[0];

    // Nibble repeated into both halves of each colour byte
    always_comb begin
        video.hs    = out_flags[3];
        video.vs    = out_flags[2];
        video.hb    = out_flags[1];
        video.vb    = out_flags[0];
        video.red   = blank ? 8'd0 : {pal_rd[11:8], pal_rd[11:8]};
        video.green = blank ? 8'd0 : {pal_rd[7:4], pal_rd[7:4]};
        video.blue  = blank ? 8'd0 : {pal_rd[3:0], pal_rd[3:0]};
    end

endmodule

//--- cps_video_top.sv
/*
 * Video output stage top level
 * Raster timing, CPU register port, layer mixer and palette output
 */
`timescale 1ns/1ps

module cps_video_top
    import video_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       cpu_req,
    input  cpu_wr_t    cpu_wr,
    input  layer_set_t layers,
    output logic       cpu_ack,
    output logic [8:0] hdump,
    output logic [8:0] vdump,
    output video_out_t video
);

    raster_t    raster;
    mix_ctrl_t  mix_ctrl;
    pal_wr_t    pal_wr;
    pal_index_t mix_pxl;

    assign hdump = raster.hdump;
    assign vdump = raster.vdump;

    video_timing i_video_timing (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .raster   ( raster   )
    );

    ppu_reg_decode i_ppu_reg_decode (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .cpu_req  ( cpu_req  ),
        .cpu_wr   ( cpu_wr   ),
        .cpu_ack  ( cpu_ack  ),
        .mix_ctrl ( mix_ctrl ),
        .pal_wr   ( pal_wr   )
    );

    layer_mix_exec i_layer_mix_exec (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .layers   ( layers   ),
        .mix_ctrl ( mix_ctrl ),
        .mix_pxl  ( mix_pxl  )
    );

    pal_result i_pal_result (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .mix_pxl  ( mix_pxl  ),
        .raster   ( raster   ),
        .pal_wr   ( pal_wr   ),
        .video    ( video    )
    );

endmodule

//--- tb_cps_video.sv
/*
 * Testbench for the video output stage
 * Trace-driven register writes and pixels, checked against a raster,
 * mixing and palette reference model
 */
`timescale 1ns/1ps
`include "video_cfg.svh"

module tb_cps_video
    import video_pkg::*;
();

    localparam int FRAME     = `H_TOTAL * `V_TOTAL;
    localparam int ACK_LIMIT = 20;

    logic       clk = 1'b0;
    logic       rst;
    logic       cpu_req;
    cpu_wr_t    cpu_wr;
    layer_set_t layers;
    logic       cpu_ack;
    logic [8:0] hdump;
    logic [8:0] vdump;
    video_out_t video;

    // Reference model of the registers and palette
    logic [1:0]  m_order [4];
    logic [3:0]  m_en;
    logic [10:0] m_ptr;
    logic [15:0] pal_model [2048];
    bit          pal_known [2048];

    // Expected colour per pixel until it leaves the pipeline
    logic [23:0] hist_rgb [4];
    bit          hist_known [4];
    bit          hist_pinned [4];
    logic [23:0] hist_trace [4];

    bit          run;
    bit          ack_seen;
    bit          pin_valid;
    int          pin_cyc;
    layer_set_t  pin_layers;
    logic [23:0] pin_rgb;
    int          cyc;
    int          errors;
    int          n_tests;
    int          n_failed;
    int          limit;
    string       cur_test;
    logic [3:0]  exp_flags;
    logic [1:0]  mon_slot;

    cps_video_top i_cps_video_top (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .cpu_req ( cpu_req ),
        .cpu_wr  ( cpu_wr  ),
        .layers  ( layers  ),
        .cpu_ack ( cpu_ack ),
        .hdump   ( hdump   ),
        .vdump   ( vdump   ),
        .video   ( video   )
    );

    always #5 clk = ~clk;

    // Cycles since reset release, cycle 0 shows hdump 0
    always @(posedge clk) begin
        if (run) begin
            cyc <= cyc + 1;
        end
    end

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("** Error %s, %s: expected %0h, actual %0h",
                     cur_test, what, expected, actual);
        end
    endtask

    // Nibble N becomes N * 0x11
    function automatic logic [23:0] expand(input logic [15:0] c);
        return {8'(c[11:8]) * 8'h11, 8'(c[7:4]) * 8'h11, 8'(c[3:0]) * 8'h11};
    endfunction

    function automatic logic [3:0] flags_of(input int c);
        int h;
        int v;
        h = c % `H_TOTAL;
        v = (c / `H_TOTAL) % `V_TOTAL;
        return {h >= `H_SYNC_START && h < `H_SYNC_END,
                v >= `V_SYNC_START && v < `V_SYNC_END,
                h >= `H_ACTIVE, v >= `V_ACTIVE};
    endfunction

    function automatic logic [10:0] mix_index(input layer_set_t l);
        logic [8:0]  px [4];
        logic [1:0]  id;
        logic [10:0] idx;
        px[0] = l.scr1;
        px[1] = l.scr2;
        px[2] = l.scr3;
        px[3] = l.obj;
        idx   = '0;
        // Back to front, the frontmost qualifying layer is written last
        for (int i = 3; i >= 0; i--) begin
            id = m_order[i];
            if (m_en[id] && px[id][3:0] != 4'(`PEN_TRANSPARENT)) begin
                idx = {id, px[id]};
            end
        end
        return idx;
    endfunction

    task automatic apply_write(input cpu_wr_t w);
        case (w.addr)
            4'(`REG_LAYER_ORDER): begin
                for (int i = 0; i < 4; i++) begin
                    m_order[i] = w.data[2*i +: 2];
                end
            end
            4'(`REG_LAYER_EN): m_en = w.data[3:0];
            4'(`REG_PAL_ADDR): m_ptr = w.data[10:0];
            4'(`REG_PAL_DATA): begin
                pal_model[m_ptr] = w.data;
                pal_known[m_ptr] = 1'b1;
                m_ptr            = m_ptr + 11'd1;
            end
            default: begin
            end
        endcase
    endtask

    task automatic drive_pixel();
        layer_set_t  l;
        logic [10:0] idx;
        logic [1:0]  slot;
        if (pin_valid && cyc == pin_cyc) begin
            l = pin_layers;
        end else begin
            l.scr1 = 9'($urandom());
            l.scr2 = 9'($urandom());
            l.scr3 = 9'($urandom());
            l.obj  = 9'($urandom());
        end
        idx               = mix_index(l);
        slot              = 2'(cyc % 4);
        hist_rgb[slot]    = expand(pal_model[idx]);
        hist_known[slot]  = pal_known[idx];
        hist_pinned[slot] = pin_valid && cyc == pin_cyc;
        hist_trace[slot]  = pin_rgb;
        layers            = l;
    endtask

    // One clock, inputs change 1 ns after the edge
    task automatic step();
        @(posedge clk);
        #1;
        // The write lands in the cycle ack rises
        if (cpu_ack && !ack_seen) begin
            apply_write(cpu_wr);
        end
        ack_seen = cpu_ack;
        drive_pixel();
    endtask

    task automatic cpu_write(input logic [3:0] a, input logic [15:0] d);
        int n;
        n           = 0;
        cpu_wr.addr = a;
        cpu_wr.data = d;
        cpu_req     = 1'b1;
        while (!cpu_ack && n < ACK_LIMIT) begin
            step();
            n++;
        end
        if (!cpu_ack) begin
            errors++;
            $display("%s: register port gave no ack within %0d cycles", cur_test, ACK_LIMIT);
            cpu_req = 1'b0;
        end else begin
            check("ack rise latency", 32'd1, 32'(n));
            cpu_req = 1'b0;
            n       = 0;
            while (cpu_ack && n < ACK_LIMIT) begin
                step();
                n++;
            end
            if (cpu_ack) begin
                errors++;
                $display("%s: ack stayed high after req was dropped", cur_test);
            end else begin
                check("ack fall latency", 32'd1, 32'(n));
            end
        end
    endtask

    task automatic run_line(input string line, input int line_no);
        logic [7:0]  kind;
        string       rest;
        int          n;
        int          h;
        int          v;
        int          target;
        int          err_before;
        logic [3:0]  a;
        logic [15:0] d;
        logic [8:0]  s1;
        logic [8:0]  s2;
        logic [8:0]  s3;
        logic [8:0]  ob;
        logic [23:0] rgb;
        kind       = line[0];
        rest       = line.substr(1, line.len() - 1);
        err_before = errors;
        case (kind)
            "W": begin
                cur_test = $sformatf("write line %0d", line_no);
                n = $sscanf(rest, "%h %h", a, d);
                if (n != 2) begin
                    errors++;
                    $display("%s: line does not hold an address and data", cur_test);
                end else begin
                    cpu_write(a, d);
                end
            end
            "P": begin
                cur_test = $sformatf("pixel line %0d", line_no);
                n = $sscanf(rest, "%d %d %h %h %h %h %h", h, v, s1, s2, s3, ob, rgb);
                if (n != 7) begin
                    errors++;
                    $display("%s: line does not hold a full pixel entry", cur_test);
                end else begin
                    // Next time the raster reaches this position
                    target = (cyc / FRAME) * FRAME + v * `H_TOTAL + h;
                    if (target <= cyc) begin
                        target += FRAME;
                    end
                    pin_layers = {s1, s2, s3, ob};
                    pin_rgb    = rgb;
                    pin_cyc    = target;
                    pin_valid  = 1'b1;
                    while (cyc < target + `PIPE_DEPTH + 1) begin
                        step();
                    end
                    pin_valid = 1'b0;
                end
            end
            "S": begin
                cur_test = $sformatf("frame end line %0d", line_no);
                while (cyc % FRAME != FRAME - 1) begin
                    step();
                end
            end
            default: begin
                cur_test = $sformatf("line %0d", line_no);
                errors++;
                $display("%s: unknown trace line kind", cur_test);
            end
        endcase
        n_tests++;
        if (errors == err_before) begin
            $display("%s: ok", cur_test);
        end else begin
            n_failed++;
            $display("%s: %0d failed checks", cur_test, errors - err_before);
        end
    endtask

    // Raster, flags and colour checked every cycle at the falling edge
    always @(negedge clk) begin
        if (run) begin
            check("hdump", 32'(cyc % `H_TOTAL), 32'(hdump));
            check("vdump", 32'((cyc / `H_TOTAL) % `V_TOTAL), 32'(vdump));
            if (cyc < `PIPE_DEPTH) begin
                exp_flags = 4'b0011;
            end else begin
                exp_flags = flags_of(cyc - `PIPE_DEPTH);
            end
            mon_slot = 2'((cyc - `PIPE_DEPTH) % 4);
            check("sync and blank flags", 32'(exp_flags),
                  32'({video.hs, video.vs, video.hb, video.vb}));
            if (exp_flags[1] || exp_flags[0]) begin
                check("blanked rgb", 32'd0, 32'({video.red, video.green, video.blue}));
            end else if (hist_known[mon_slot]) begin
                check("rgb", 32'(hist_rgb[mon_slot]),
                      32'({video.red, video.green, video.blue}));
            end
            if (cyc >= `PIPE_DEPTH && hist_pinned[mon_slot]) begin
                check("trace rgb", 32'(hist_trace[mon_slot]),
                      32'({video.red, video.green, video.blue}));
            end
        end
    end

    initial begin
        wait (limit > 0);
        repeat (limit) @(posedge clk);
        $display("Watchdog: run did not finish within %0d cycles", limit);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        int    fd;
        int    n_lines;
        int    line_no;
        string line;
        rst     = 1'b1;
        cpu_req = 1'b0;
        cpu_wr  = '0;
        layers  = '0;
        m_en    = 4'hf;
        m_ptr   = '0;
        n_lines = 0;
        line_no = 0;
        for (int i = 0; i < 4; i++) begin
            m_order[i] = 2'(i);
        end
        void'($urandom(32'h5f66));
        fd = $fopen("video_trace.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Cannot open the trace file video_trace.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                n_lines++;
            end
            $fclose(fd);
            fd = $fopen("video_trace.txt", "r");
        end
        limit = n_lines * 40 + 2 * FRAME;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        run = 1'b1;
        drive_pixel();
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                line_no++;
                if (line.len() > 1 && line[0] != "#") begin
                    run_line(line, line_no);
                end
            end
            $fclose(fd);
        end
        cur_test = "pipeline flush";
        repeat (`PIPE_DEPTH + 1) step();
        $display("Tests run %0d, tests failed %0d, failed checks %0d",
                 n_tests, n_failed, errors);
        if (errors == 0 && n_tests > 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- video_trace.txt
# W <reg addr hex> <data hex> | P <hdump> <vdump> <scr1> <scr2> <scr3> <obj> <rgb hex>
# Layer pixels are 9-bit hex, palette in bits 8:4 and pen in 3:0 | S runs to frame end
W 2 000
W 3 0123
W 3 0456
W 2 235
W 3 0f00
W 2 627
W 3 00f0
W 2 014
W 3 000f
W 2 442
W 3 fa5c
P 10 2 001 035 042 027 445566
P 20 2 014 035 042 027 0000ff
P 30 2 01f 035 042 027 ff0000
P 40 2 01f 03f 04f 02f 112233
P 50 2 01f 03f 042 027 aa55cc
W 0 93
P 10 5 014 035 042 027 00ff00
P 20 5 014 035 042 02f 0000ff
W 1 e
P 10 7 014 035 042 02f ff0000
W 1 6
P 10 9 014 03f 042 027 aa55cc
W 1 0
P 10 11 014 035 042 027 112233
W 1 f
W 0 e4
P 60 13 01f 035 042 027 ff0000
P 400 14 014 035 042 027 000000
P 383 15 014 035 042 027 0000ff
P 384 15 014 035 042 027 000000
P 100 223 014 035 042 027 0000ff
P 100 224 014 035 042 027 000000
S

//--- vlog.f
+incdir+.
video_pkg.sv
video_timing.sv
ppu_reg_decode.sv
layer_mix_exec.sv
pal_result.sv
cps_video_top.sv
tb_cps_video.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the video output stage testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_cps_video -Mdir obj_dir

sim_out=$(./obj_dir/Vtb_cps_video)
echo "$sim_out"

if grep -qx "Simulation PASSED" <<< "$sim_out"; then
    exit 0
fi
exit 1
